//--- Makefile
TOP       ?= input_pipe_tb
RTL_TOP   ?= input_pipe
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+.
input_pipe_pkg.sv
word_gearbox.sv
pipe_ctrl.sv
image_router.sv
weight_disperser.sv
input_pipe.sv
input_pipe_tb.sv

//--- image_router.sv
`default_nettype none

module image_router (
  input  input_pipe_pkg::layer_mode_e  mode,
  input  input_pipe_pkg::image_frame_t frame_0,
  input  input_pipe_pkg::image_frame_t frame_1,
  output input_pipe_pkg::image_out_t   image
);

  import input_pipe_pkg::*;

  logic is_pool;

  assign is_pool = (mode == mode_1x1_pool) || (mode == mode_3x3_pool);

  always_comb begin
    // low half always from stream 0
    image.frame_0 = frame_0;
    // maxpool pairs two rows, otherwise stream 0 is duplicated
    if (is_pool) begin
      image.frame_1 = frame_1;
    end else begin
      image.frame_1 = frame_0;
    end
  end

endmodule

`default_nettype wire

//--- input_pipe.sv
`default_nettype none

module input_pipe (
  input  logic                                              aclk,
  input  logic                                              aresetn,
  input  input_pipe_pkg::layer_mode_e                       mode,
  // weight DMA in
  input  logic                                              w_dma_valid,
  input  input_pipe_pkg::word_t [input_pipe_pkg::w_dma_words-1:0]  w_dma_data,
  output logic                                              w_dma_ready,
  // image DMA 0 in
  input  logic                                              im_dma_0_valid,
  input  input_pipe_pkg::word_t [input_pipe_pkg::im_dma_words-1:0] im_dma_0_data,
  output logic                                              im_dma_0_ready,
  // image DMA 1 in
  input  logic                                              im_dma_1_valid,
  input  input_pipe_pkg::word_t [input_pipe_pkg::im_dma_words-1:0] im_dma_1_data,
  output logic                                              im_dma_1_ready,
  // towards the weight rotator
  output logic                                              rot_out_valid,
  output input_pipe_pkg::rot_beat_t                         rot_out_data,
  input  logic                                              rot_out_ready,
  // back from the weight rotator
  input  logic                                              rot_in_valid,
  input  input_pipe_pkg::rot_beat_t                         rot_in_data,
  output logic                                              rot_in_ready,
  // joined output
  output logic                                              m_valid,
  output input_pipe_pkg::image_out_t                        image,
  output input_pipe_pkg::weights_t                          weights,
  input  logic                                              m_ready
);

  import input_pipe_pkg::*;

  image_frame_t             frame_0;
  image_frame_t             frame_1;
  logic                     frame_0_valid;
  logic                     frame_1_valid;
  logic                     frame_0_ready;
  logic                     frame_1_ready;
  logic                     im_1_enable;
  logic                     im_1_in_valid;
  logic                     im_1_in_ready;
  weights_t                 w_set;
  word_t [half_words-1:0]   w_half;
  logic                     w_set_valid;
  logic                     w_half_valid;
  logic                     w_set_ready;
  logic                     w_half_ready;
  logic                     w_set_in_valid;
  logic                     w_half_in_valid;
  logic                     w_set_in_ready;
  logic                     w_half_in_ready;

  // stream 1 gated off without maxpool
  assign im_1_in_valid  = im_dma_1_valid && im_1_enable;
  assign im_dma_1_ready = im_1_in_ready && im_1_enable;

  // image DMA beats into ten-word frames
  word_gearbox #(.in_words(im_dma_words), .out_words(frame_words)) im_0_gearbox (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (im_dma_0_valid),
    .in_data   (im_dma_0_data),
    .in_ready  (im_dma_0_ready),
    .out_valid (frame_0_valid),
    .out_data  (frame_0),
    .out_ready (frame_0_ready)
  );

  word_gearbox #(.in_words(im_dma_words), .out_words(frame_words)) im_1_gearbox (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (im_1_in_valid),
    .in_data   (im_dma_1_data),
    .in_ready  (im_1_in_ready),
    .out_valid (frame_1_valid),
    .out_data  (frame_1),
    .out_ready (frame_1_ready)
  );

  // weight DMA beats into rotator beats
  word_gearbox #(.in_words(w_dma_words), .out_words(rot_words)) w_dma_gearbox (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (w_dma_valid),
    .in_data   (w_dma_data),
    .in_ready  (w_dma_ready),
    .out_valid (rot_out_valid),
    .out_data  (rot_out_data),
    .out_ready (rot_out_ready)
  );

  // three rotator beats per 3x3 set
  word_gearbox #(.in_words(rot_words), .out_words(weight_words)) w_set_gearbox (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (w_set_in_valid),
    .in_data   (rot_in_data),
    .in_ready  (w_set_in_ready),
    .out_valid (w_set_valid),
    .out_data  (w_set),
    .out_ready (w_set_ready)
  );

  // one and a half rotator beats per maxpool half set
  word_gearbox #(.in_words(rot_words), .out_words(half_words)) w_half_gearbox (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (w_half_in_valid),
    .in_data   (rot_in_data),
    .in_ready  (w_half_in_ready),
    .out_valid (w_half_valid),
    .out_data  (w_half),
    .out_ready (w_half_ready)
  );

  pipe_ctrl pipe_ctrl_i (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .mode            (mode),
    .frame_0_valid   (frame_0_valid),
    .frame_1_valid   (frame_1_valid),
    .w_set_valid     (w_set_valid),
    .w_half_valid    (w_half_valid),
    .w_set_in_ready  (w_set_in_ready),
    .w_half_in_ready (w_half_in_ready),
    .rot_in_valid    (rot_in_valid),
    .m_ready         (m_ready),
    .frame_0_ready   (frame_0_ready),
    .frame_1_ready   (frame_1_ready),
    .im_1_enable     (im_1_enable),
    .w_set_in_valid  (w_set_in_valid),
    .w_half_in_valid (w_half_in_valid),
    .w_set_ready     (w_set_ready),
    .w_half_ready    (w_half_ready),
    .rot_in_ready    (rot_in_ready),
    .m_valid         (m_valid)
  );

  image_router image_router_i (
    .mode    (mode),
    .frame_0 (frame_0),
    .frame_1 (frame_1),
    .image   (image)
  );

  weight_disperser weight_disperser_i (
    .mode     (mode),
    .rot_beat (rot_in_data),
    .w_set    (w_set),
    .w_half   (w_half),
    .weights  (weights)
  );

endmodule

`default_nettype wire

//--- input_pipe_pkg.sv
`default_nettype none

package input_pipe_pkg;

  // word and array sizes
  localparam int unsigned data_width   = 8;
  // middle words per frame, one per conv unit
  localparam int unsigned conv_units   = 8;
  localparam int unsigned conv_cores   = 4;
  localparam int unsigned conv_pairs   = 2;
  // top edge + middle words + bottom edge
  localparam int unsigned frame_words  = conv_units + 2;
  localparam int unsigned im_dma_words = 2;
  localparam int unsigned w_dma_words  = 4;
  // three words per core on the rotator
  localparam int unsigned rot_words    = 3 * conv_cores;
  // nine words per core, full 3x3 kernel set
  localparam int unsigned weight_words = 9 * conv_cores;
  // nine words per core pair for 3x3 maxpool
  localparam int unsigned half_words   = 9 * conv_pairs;

  typedef logic [data_width-1:0] word_t;

  // layer mode, one code per pooling and kernel combination
  typedef enum logic [1:0] {
    mode_1x1      = 2'd0,
    mode_1x1_pool = 2'd1,
    mode_3x3      = 2'd2,
    mode_3x3_pool = 2'd3
  } layer_mode_e;

  // top edge word in the low position, bottom edge word on top
  typedef struct packed {
    word_t                  bot;
    word_t [conv_units-1:0] mid;
    word_t                  top;
  } image_frame_t;

  // frame_0 in the low half
  typedef struct packed {
    image_frame_t frame_1;
    image_frame_t frame_0;
  } image_out_t;

  // core 0 in the lowest nine words
  typedef word_t [weight_words-1:0] weights_t;

  // core 0 in the lowest three words
  typedef word_t [rot_words-1:0] rot_beat_t;

endpackage

`default_nettype wire

//--- input_pipe_tb_tasks.svh
`ifndef INPUT_PIPE_TB_TASKS_SVH
`define INPUT_PIPE_TB_TASKS_SVH

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
    errors++;
  end
endtask

task automatic check_image(input string name, input image_out_t got, input image_out_t exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic check_weights(input string name, input weights_t got, input weights_t exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  end
endtask

// inputs idle, mode held until the next reset
task automatic apply_reset(input layer_mode_e new_mode);
  @(posedge aclk);
  #1;
  aresetn        = 1'b0;
  mode           = new_mode;
  w_dma_valid    = 1'b0;
  im_dma_0_valid = 1'b0;
  im_dma_1_valid = 1'b0;
  m_ready        = 1'b0;
  im_0_words.delete();
  im_1_words.delete();
  w_words.delete();
  repeat (4) @(posedge aclk);
  #1;
  aresetn = 1'b1;
endtask

function automatic bit pool_mode();
  return (mode == mode_1x1_pool) || (mode == mode_3x3_pool);
endfunction

// frame n: first word is the top edge, last the bottom edge
function automatic image_out_t expected_image(input int n);
  image_out_t                    e;
  logic [data_width*frame_words-1:0] f0;
  logic [data_width*frame_words-1:0] f1;
  for (int k = 0; k < frame_words; k++) begin
    f0[data_width*k +: data_width] = im_0_words[frame_words*n + k];
    if (pool_mode()) begin
      f1[data_width*k +: data_width] = im_1_words[frame_words*n + k];
    end else begin
      f1[data_width*k +: data_width] = im_0_words[frame_words*n + k];
    end
  end
  e.frame_0 = f0;
  e.frame_1 = f1;
  return e;
endfunction

function automatic weights_t expected_weights(input int n);
  weights_t e;
  case (mode)
    mode_3x3: begin
      for (int k = 0; k < weight_words; k++) e[k] = w_words[weight_words*n + k];
    end
    // block p of the half set, then block p again
    mode_3x3_pool: begin
      for (int p = 0; p < conv_pairs; p++)
        for (int r = 0; r < 2; r++)
          for (int k = 0; k < 9; k++) e[18*p + 9*r + k] = w_words[half_words*n + 9*p + k];
    end
    // three words of core c, three times over
    default: begin
      for (int c = 0; c < conv_cores; c++)
        for (int r = 0; r < 3; r++)
          for (int k = 0; k < 3; k++) e[9*c + 3*r + k] = w_words[rot_words*n + 3*c + k];
    end
  endcase
  return e;
endfunction

// offer beats in order, each held until its transfer
task automatic drive_stream(input int sel, input int beats);
  int   n;
  int   t;
  logic rdy;
  n = (sel == s_w) ? w_dma_words : im_dma_words;
  for (int b = 0; b < beats; b++) begin
    @(posedge aclk);
    #1;
    for (int k = 0; k < n; k++) begin
      case (sel)
        s_im_0:  im_dma_0_data[k] = im_0_words[b*n + k];
        s_im_1:  im_dma_1_data[k] = im_1_words[b*n + k];
        default: w_dma_data[k] = w_words[b*n + k];
      endcase
    end
    case (sel)
      s_im_0:  im_dma_0_valid = 1'b1;
      s_im_1:  im_dma_1_valid = 1'b1;
      default: w_dma_valid = 1'b1;
    endcase
    // sample ready mid-cycle, the transfer is the next rising edge
    t = 0;
    do begin
      @(negedge aclk);
      rdy = (sel == s_im_0) ? im_dma_0_ready : (sel == s_im_1) ? im_dma_1_ready : w_dma_ready;
      t++;
    end while (!rdy && t < wait_limit);
    if (!rdy) begin
      $display("timeout: input stream %0d never became ready for beat %0d", sel, b);
      errors++;
      break;
    end
  end
  @(posedge aclk);
  #1;
  im_dma_0_valid = (sel == s_im_0) ? 1'b0 : im_dma_0_valid;
  im_dma_1_valid = (sel == s_im_1) ? 1'b0 : im_dma_1_valid;
  w_dma_valid    = (sel == s_w) ? 1'b0 : w_dma_valid;
endtask

// m_ready low for hold cycles, then steady or random
task automatic collect_outputs(input int outputs, input int hold, input bit random_ready);
  int n;
  int t;
  n = 0;
  t = 0;
  while (n < outputs) begin
    @(posedge aclk);
    #1;
    if (hold > 0) begin
      m_ready = 1'b0;
      hold--;
    end else begin
      m_ready = random_ready ? 1'($urandom) : 1'b1;
    end
    @(negedge aclk);
    if (m_valid && m_ready) begin
      check_image("image", image, expected_image(n));
      check_weights("weights", weights, expected_weights(n));
      n++;
      t = 0;
    end else if (t == wait_limit) begin
      $display("timeout: output %0d of %0d never arrived", n, outputs);
      errors++;
      break;
    end else begin
      t++;
    end
  end
  // every word used up, so no extra output may follow
  @(posedge aclk);
  #1;
  m_ready = 1'b0;
  @(negedge aclk);
  check_bit("m_valid", m_valid, 1'b0);
endtask

// frames must be even for the 3x3 maxpool word count
task automatic run_stream(input layer_mode_e new_mode, input int frames, input int hold,
                          input bit random_ready);
  int w_total;
  apply_reset(new_mode);
  case (new_mode)
    mode_3x3:      w_total = weight_words * frames;
    mode_3x3_pool: w_total = half_words * frames;
    default:       w_total = rot_words * frames;
  endcase
  for (int i = 0; i < frame_words * frames; i++) begin
    im_0_words.push_back(word_t'($urandom));
    if (pool_mode()) im_1_words.push_back(word_t'($urandom));
  end
  for (int i = 0; i < w_total; i++) w_words.push_back(word_t'($urandom));
  fork
    drive_stream(s_im_0, frame_words * frames / im_dma_words);
    if (pool_mode()) drive_stream(s_im_1, frame_words * frames / im_dma_words);
    drive_stream(s_w, w_total / w_dma_words);
    collect_outputs(frames, hold, random_ready);
  join
endtask

task automatic idle_after_reset();
  apply_reset(mode_3x3);
  @(negedge aclk);
  check_bit("m_valid", m_valid, 1'b0);
  check_bit("im_dma_0_ready", im_dma_0_ready, 1'b0);
  check_bit("im_dma_1_ready", im_dma_1_ready, 1'b0);
  check_bit("w_dma_ready", w_dma_ready, 1'b0);
  check_bit("rot_out_valid", rot_out_valid, 1'b0);
  check_bit("rot_in_ready", rot_in_ready, 1'b0);
  // readies come up one cycle after release
  @(negedge aclk);
  check_bit("im_dma_0_ready", im_dma_0_ready, 1'b1);
  check_bit("w_dma_ready", w_dma_ready, 1'b1);
  check_bit("im_dma_1_ready", im_dma_1_ready, 1'b0);
  // 3x3 set gearbox takes rotator beats
  check_bit("rot_in_ready", rot_in_ready, 1'b1);
  check_bit("rot_out_valid", rot_out_valid, 1'b0);
endtask

task automatic copy_frames_3x3();
  run_stream(mode_3x3, 4, 0, 1'b0);
endtask

task automatic pair_frames_3x3_pool();
  run_stream(mode_3x3_pool, 4, 0, 1'b0);
endtask

task automatic repeat_words_1x1();
  run_stream(mode_1x1, 4, 0, 1'b0);
  run_stream(mode_1x1_pool, 4, 0, 1'b0);
endtask

task automatic stall_and_resume();
  run_stream(mode_3x3_pool, 6, 30, 1'b1);
  run_stream(mode_1x1_pool, 5, 30, 1'b1);
endtask

`endif

//--- input_pipe_tb.sv
`default_nettype none

module input_pipe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import input_pipe_pkg::*;

  // cycles any single wait may take
  localparam int unsigned wait_limit = 2000;
  // stream ids for the DMA drivers
  localparam int s_im_0 = 0;
  localparam int s_im_1 = 1;
  localparam int s_w    = 2;

  logic                      aclk;
  logic                      aresetn;
  layer_mode_e               mode;
  logic                      w_dma_valid;
  word_t [w_dma_words-1:0]   w_dma_data;
  logic                      w_dma_ready;
  logic                      im_dma_0_valid;
  word_t [im_dma_words-1:0]  im_dma_0_data;
  logic                      im_dma_0_ready;
  logic                      im_dma_1_valid;
  word_t [im_dma_words-1:0]  im_dma_1_data;
  logic                      im_dma_1_ready;
  logic                      rot_out_valid;
  rot_beat_t                 rot_out_data;
  logic                      rot_out_ready;
  logic                      rot_in_valid;
  rot_beat_t                 rot_in_data;
  logic                      rot_in_ready;
  logic                      m_valid;
  image_out_t                image;
  weights_t                  weights;
  logic                      m_ready;

  // model queues, words in transfer order per stream
  word_t       im_0_words[$];
  word_t       im_1_words[$];
  word_t       w_words[$];
  int unsigned errors;

  // rotator stand-in, beats come straight back
  assign rot_in_valid  = rot_out_valid;
  assign rot_in_data   = rot_out_data;
  assign rot_out_ready = rot_in_ready;

  input_pipe input_pipe_i (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .mode           (mode),
    .w_dma_valid    (w_dma_valid),
    .w_dma_data     (w_dma_data),
    .w_dma_ready    (w_dma_ready),
    .im_dma_0_valid (im_dma_0_valid),
    .im_dma_0_data  (im_dma_0_data),
    .im_dma_0_ready (im_dma_0_ready),
    .im_dma_1_valid (im_dma_1_valid),
    .im_dma_1_data  (im_dma_1_data),
    .im_dma_1_ready (im_dma_1_ready),
    .rot_out_valid  (rot_out_valid),
    .rot_out_data   (rot_out_data),
    .rot_out_ready  (rot_out_ready),
    .rot_in_valid   (rot_in_valid),
    .rot_in_data    (rot_in_data),
    .rot_in_ready   (rot_in_ready),
    .m_valid        (m_valid),
    .image          (image),
    .weights        (weights),
    .m_ready        (m_ready)
  );

  `include "input_pipe_tb_tasks.svh"

  // 100 ns clock
  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  initial begin
    errors         = 0;
    void'($urandom(32'haf65));
    aresetn        = 1'b0;
    mode           = mode_3x3;
    w_dma_valid    = 1'b0;
    w_dma_data     = '0;
    im_dma_0_valid = 1'b0;
    im_dma_0_data  = '0;
    im_dma_1_valid = 1'b0;
    im_dma_1_data  = '0;
    m_ready        = 1'b0;
    idle_after_reset();
    copy_frames_3x3();
    pair_frames_3x3_pool();
    repeat_words_1x1();
    stall_and_resume();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pipe_ctrl.sv
`default_nettype none

module pipe_ctrl (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  input_pipe_pkg::layer_mode_e mode,
  input  logic                        frame_0_valid,
  input  logic                        frame_1_valid,
  input  logic                        w_set_valid,
  input  logic                        w_half_valid,
  input  logic                        w_set_in_ready,
  input  logic                        w_half_in_ready,
  input  logic                        rot_in_valid,
  input  logic                        m_ready,
  output logic                        frame_0_ready,
  output logic                        frame_1_ready,
  output logic                        im_1_enable,
  output logic                        w_set_in_valid,
  output logic                        w_half_in_valid,
  output logic                        w_set_ready,
  output logic                        w_half_ready,
  output logic                        rot_in_ready,
  output logic                        m_valid
);

  import input_pipe_pkg::*;

  logic is_pool;
  logic sel_3x3;
  logic sel_3x3_pool;
  logic im_ok;
  logic w_ok;
  logic pop;

  // mode decode
  assign is_pool      = (mode == mode_1x1_pool) || (mode == mode_3x3_pool);
  assign sel_3x3      = (mode == mode_3x3);
  assign sel_3x3_pool = (mode == mode_3x3_pool);

  // frame 1 only takes part when pooling
  assign im_ok = frame_0_valid && (!is_pool || frame_1_valid);

  // weight source picked by the mode, rotator in for 1x1
  always_comb begin
    unique case (mode)
      mode_3x3:      w_ok = w_set_valid;
      mode_3x3_pool: w_ok = w_half_valid;
      default:       w_ok = rot_in_valid;
    endcase
  end

  // output join
  assign m_valid = im_ok && w_ok;
  assign pop     = m_valid && m_ready;

  // both frame gearboxes released together in pool modes
  assign frame_0_ready = pop;
  assign frame_1_ready = pop && is_pool;
  // idle image stream 1 held off
  assign im_1_enable   = is_pool;

  // steer rotator beats into the active weight gearbox only
  assign w_set_in_valid  = rot_in_valid && sel_3x3;
  assign w_half_in_valid = rot_in_valid && sel_3x3_pool;

  // pop releases the weight set in use
  assign w_set_ready  = pop && sel_3x3;
  assign w_half_ready = pop && sel_3x3_pool;

  // 1x1 consumes the rotator beat directly on a pop
  always_comb begin
    unique case (mode)
      mode_3x3:      rot_in_ready = w_set_in_ready;
      mode_3x3_pool: rot_in_ready = w_half_in_ready;
      default:       rot_in_ready = pop;
    endcase
  end

  // mode only changes while held in reset
  a_mode_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    $stable(mode)
  );

  // sink must drive ready once output is offered
  a_m_ready_known: assert property (
    @(posedge aclk) disable iff (!aresetn)
    m_valid |-> !$isunknown(m_ready)
  );

endmodule

`default_nettype wire

//--- weight_disperser.sv
`default_nettype none

module weight_disperser (
  input  input_pipe_pkg::layer_mode_e                        mode,
  input  input_pipe_pkg::rot_beat_t                          rot_beat,
  input  input_pipe_pkg::weights_t                           w_set,
  input  input_pipe_pkg::word_t [input_pipe_pkg::half_words-1:0] w_half,
  output input_pipe_pkg::weights_t                           weights
);

  import input_pipe_pkg::*;

  weights_t half_spread;
  weights_t rot_spread;

  // 3x3 maxpool: each pair gets its nine words twice
  always_comb begin
    for (int p = 0; p < conv_pairs; p++) begin
      for (int k = 0; k < 18; k++) begin
        half_spread[18*p + k] = w_half[9*p + (k % 9)];
      end
    end
  end

  // 1x1: each core's three words repeated three times
  always_comb begin
    for (int c = 0; c < conv_cores; c++) begin
      for (int k = 0; k < 9; k++) begin
        rot_spread[9*c + k] = rot_beat[3*c + (k % 3)];
      end
    end
  end

  // select by mode
  always_comb begin
    unique case (mode)
      mode_3x3:      weights = w_set;
      mode_3x3_pool: weights = half_spread;
      default:       weights = rot_spread;
    endcase
  end

endmodule

`default_nettype wire

//--- word_gearbox.sv
`default_nettype none

module word_gearbox #(
  parameter int unsigned in_words  = 2,
  parameter int unsigned out_words = 10
) (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic                                    in_valid,
  input  input_pipe_pkg::word_t [in_words-1:0]    in_data,
  output logic                                    in_ready,
  output logic                                    out_valid,
  output input_pipe_pkg::word_t [out_words-1:0]   out_data,
  input  logic                                    out_ready
);

  import input_pipe_pkg::*;

  // room for one full output beat plus one incoming beat
  localparam int unsigned cap    = in_words + out_words;
  localparam int unsigned fill_w = $clog2(cap + 1);

  word_t [cap-1:0]   buf_q;
  word_t [cap-1:0]   buf_n;
  logic [fill_w-1:0] fill_q;
  logic [fill_w-1:0] fill_n;
  // fill after the pop, where the new beat lands
  logic [fill_w-1:0] base;
  logic              out_valid_q;
  logic              in_ready_q;
  logic              push;
  logic              pop;

  assign push = in_valid && in_ready_q;
  assign pop  = out_valid_q && out_ready;

  // oldest words always sit at the bottom of the buffer
  assign out_data  = buf_q[out_words-1:0];
  assign out_valid = out_valid_q;
  assign in_ready  = in_ready_q;

  always_comb begin
    buf_n = buf_q;
    base  = fill_q;
    // drop the beat just taken, shift the leftovers down
    if (pop) begin
      for (int i = 0; i < in_words; i++) begin
        buf_n[i] = buf_q[i + out_words];
      end
      base = fill_q - fill_w'(out_words);
    end
    // append the new beat right after what is kept
    if (push) begin
      for (int j = 0; j < in_words; j++) begin
        buf_n[base + j] = in_data[j];
      end
    end
    fill_n = base + (push ? fill_w'(in_words) : '0);
  end

  // control state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      fill_q      <= '0;
      out_valid_q <= 1'b0;
      in_ready_q  <= 1'b0;
    end else begin
      fill_q      <= fill_n;
      // valid as soon as one whole output beat is held
      out_valid_q <= fill_n >= fill_w'(out_words);
      // accept while a full input beat still fits
      in_ready_q  <= fill_n <= fill_w'(out_words);
    end
  end

  // payload only
  always_ff @(posedge aclk) begin
    buf_q <= buf_n;
  end

  // held output beat must not move under back-pressure
  a_out_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_valid_q && !out_ready |=> $stable(out_data)
  );

  // no overflow of the shift buffer
  a_fill_cap: assert property (
    @(posedge aclk) disable iff (!aresetn)
    fill_q <= fill_w'(cap)
  );

endmodule

`default_nettype wire
